// ==== Makefile ====
# Verilator lint and simulation of the mini RV32I core testbench

VERILATOR ?= verilator
TOP       := tb_mini_riscv_core
FILELIST  := compile.f
FLAGS     := --timing --assert --timescale 1ns/100ps
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/core_pkg.sv ====
// microarchitecture types and pipeline register structs shared by every stage of the core
package core_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int WORD_W   = 32;  // data and address width
  localparam int NUM_REGS = 32;  // x0..x31, x0 hardwired

  typedef logic [WORD_W-1:0]           word_t;     // data or address word
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;  // register index

  // pc value held until fetch is first enabled
  // the real start address is boot_addr_i, sampled on the first enable
  localparam word_t PC_RESET = '0;

  //////////////////////////////////////////////////
  // pipeline registers
  //////////////////////////////////////////////////

  // fetch -> decode
  typedef struct packed {
    logic  valid;
    word_t instr;  // raw instruction word
    word_t pc;     // address it was fetched from
  } if_id_t;

  // decode -> execute
  typedef struct packed {
    logic             valid;
    isa_pkg::alu_op_e alu_op;
    word_t            operand_a;   // rs1, forwarded
    word_t            operand_b;   // rs2 or immediate
    word_t            store_data;  // rs2 for SW
    reg_idx_t         rd;
    logic             reg_we;      // ALU result goes to rd
    logic             store_en;    // word store to data memory
  } id_ex_t;

  // execute write-back, also the forwarding source for decode
  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    wdata;
  } wb_fwd_t;

endpackage

// ==== common/isa_pkg.sv ====
// RV32I encodings and ALU operation codes used by the decoder and the execute stage
package isa_pkg;

  // major opcodes, instr[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3, instr[14:12]
  localparam logic [2:0] F3_ADD  = 3'b000;  // also SUB
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL / SRA
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_SW   = 3'b010;  // store word

  // funct7 selecting SUB and SRA/SRAI
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B   // LUI
  } alu_op_e;

  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// ==== compile.f ====
common/isa_pkg.sv
common/core_pkg.sv
fetch/if_stage.sv
decode/register_file.sv
decode/id_stage.sv
rtl/ex_stage.sv
rtl/mini_riscv_core.sv
dv/tb_mini_riscv_core.sv

// ==== decode/id_stage.sv ====
// decode stage with instruction decode, operand forwarding and the decode/execute register
`timescale 1ns/100ps

module id_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::if_id_t    if_id_i,
  output logic                id_ready_o,
  input  logic                ex_ready_i,
  input  core_pkg::wb_fwd_t   wb_i,
  output core_pkg::id_ex_t    id_ex_o
);

  core_pkg::word_t    instr;
  core_pkg::reg_idx_t rs1, rs2, rd;
  logic [6:0]         opcode, funct7;
  logic [2:0]         funct3;
  core_pkg::word_t    imm_i, imm_shamt, imm_u, imm_s;
  core_pkg::word_t    rf_a, rf_b;    // raw register file reads
  core_pkg::word_t    rs1_val, rs2_val;
  isa_pkg::alu_op_e   alu_op;
  core_pkg::word_t    op_b;
  logic               reg_we, store_en;
  core_pkg::id_ex_t   id_ex_q;

  // instruction fields
  assign instr  = if_id_i.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // immediates
  assign imm_i     = {{20{instr[31]}}, instr[31:20]};
  assign imm_shamt = {27'b0, instr[24:20]};
  assign imm_u     = {instr[31:12], 12'b0};
  assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};

  register_file u_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .wb_i      (wb_i)
  );

  //////////////////////////////////////////////////
  // forwarding from execute
  //////////////////////////////////////////////////

  // execute writes at the same edge decode hands over, so its value wins
  assign rs1_val = (wb_i.we && wb_i.rd == rs1 && rs1 != '0) ? wb_i.wdata : rf_a;
  assign rs2_val = (wb_i.we && wb_i.rd == rs2 && rs2 != '0) ? wb_i.wdata : rf_b;

  //////////////////////////////////////////////////
  // decoder
  //////////////////////////////////////////////////

  // funct3 -> ALU op, shared by OP and OP-IMM
  function automatic isa_pkg::alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
    isa_pkg::alu_op_e op;
    case (f3)
      isa_pkg::F3_ADD:  op = alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      isa_pkg::F3_SLL:  op = isa_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  op = isa_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: op = isa_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  op = isa_pkg::ALU_XOR;
      isa_pkg::F3_SR:   op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      isa_pkg::F3_OR:   op = isa_pkg::ALU_OR;
      default:          op = isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb
  begin
    alu_op   = isa_pkg::ALU_ADD;
    op_b     = rs2_val;
    reg_we   = 1'b0;  // unknown encodings retire as no-ops
    store_en = 1'b0;
    case (opcode)
      isa_pkg::OPC_LUI:
      begin
        alu_op = isa_pkg::ALU_PASS_B;
        op_b   = imm_u;
        reg_we = 1'b1;
      end
      isa_pkg::OPC_OP_IMM:
      begin
        op_b = imm_i;
        if (funct3 == isa_pkg::F3_SLL || funct3 == isa_pkg::F3_SR)
        begin
          op_b   = imm_shamt;
          // shifts need a clean funct7, alt only for SRAI
          reg_we = (funct7 == 7'b0) ||
                   (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_SR);
          alu_op = f3_to_op(funct3, funct7 == isa_pkg::F7_ALT);
        end
        else
        begin
          reg_we = 1'b1;
          alu_op = f3_to_op(funct3, 1'b0);  // ADDI never subtracts
        end
      end
      isa_pkg::OPC_OP:
      begin
        reg_we = (funct7 == 7'b0) ||
                 (funct7 == isa_pkg::F7_ALT &&
                  (funct3 == isa_pkg::F3_ADD || funct3 == isa_pkg::F3_SR));
        alu_op = f3_to_op(funct3, funct7 == isa_pkg::F7_ALT);
      end
      isa_pkg::OPC_STORE:
      begin
        // address = rs1 + imm_s through the adder
        op_b     = imm_s;
        store_en = (funct3 == isa_pkg::F3_SW);
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // decode/execute register
  //////////////////////////////////////////////////

  assign id_ready_o = ex_ready_i;  // decode itself never stalls

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      id_ex_q <= '0;
    else if (ex_ready_i)
    begin
      id_ex_q.valid      <= if_id_i.valid;  // bubble when fetch is empty
      id_ex_q.alu_op     <= alu_op;
      id_ex_q.operand_a  <= rs1_val;
      id_ex_q.operand_b  <= op_b;
      id_ex_q.store_data <= rs2_val;
      id_ex_q.rd         <= rd;
      id_ex_q.reg_we     <= reg_we && if_id_i.valid;
      id_ex_q.store_en   <= store_en && if_id_i.valid;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

// ==== decode/register_file.sv ====
// integer register file x1..x31 with two combinational reads and one write, x0 reads zero
`timescale 1ns/100ps

module register_file (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::reg_idx_t  raddr_a_i,
  input  core_pkg::reg_idx_t  raddr_b_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o,
  input  core_pkg::wb_fwd_t   wb_i        // write port from execute
);

  core_pkg::word_t regs [1:core_pkg::NUM_REGS-1];  // x0 not stored

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < core_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wb_i.we && wb_i.rd != '0)  // x0 writes dropped
      regs[wb_i.rd] <= wb_i.wdata;
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== dv/tb_mini_riscv_core.sv ====
// testbench for the core, runs a table of ALU/LUI programs that each end in a word store
`timescale 1ns/100ps

module tb_mini_riscv_core;

  localparam int          CLK_NS       = 4;
  localparam int          RESET_CYCLES = 5;
  localparam int          IDLE_CYCLES  = 8;   // fetch_enable_i held low after reset
  localparam int          DRAIN_CYCLES = 40;  // NOPs only, no further store allowed
  localparam int          NUM_TESTS    = 22;
  localparam int          IMEM_AW      = 8;
  localparam int          IMEM_WORDS   = 1 << IMEM_AW;
  localparam logic [31:0] BOOT_ADDR    = 32'h0000_0400;
  // 8 instructions per entry, 10 cycles each at most, plus reset/idle/drain
  localparam int WATCHDOG_NS = NUM_TESTS * 8 * 10 * CLK_NS
                             + (RESET_CYCLES + IDLE_CYCLES + DRAIN_CYCLES) * CLK_NS;

  typedef struct packed {
    logic [63:0]      name;  // 8 characters
    isa_pkg::alu_op_e op;    // ALU_PASS_B stands for LUI
    logic [31:0]      a;
    logic [31:0]      b;     // rs2 value or sign-extended immediate
    logic             imm;   // immediate form
    logic [4:0]       rd;    // 3, or 0 for the x0 case
    logic [31:0]      exp;   // filled from the reference model
  } test_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              fetch_enable_i;
  core_pkg::word_t   boot_addr_i;
  logic              instr_req_o, instr_gnt_i, instr_rvalid_i;
  core_pkg::word_t   instr_addr_o, instr_rdata_i;
  logic              data_req_o, data_gnt_i;
  core_pkg::word_t   data_addr_o, data_wdata_o;

  test_t             tests [NUM_TESTS];
  core_pkg::word_t   imem [IMEM_WORDS];
  store_t            store_q [$];   // granted stores, oldest first
  int                store_cnt = 0;
  int                pass_cnt  = 0;
  int                fail_cnt  = 0;
  integer            seed      = 32'hcb55;

  mini_riscv_core DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o)
  );

  always #(CLK_NS / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // reference model and encoders
  //////////////////////////////////////////////////

  function automatic logic [31:0] ref_result(isa_pkg::alu_op_e op, logic [31:0] a,
                                             logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];  // RV32I shifts by low five bits
    case (op)
      isa_pkg::ALU_ADD:  return a + b;
      isa_pkg::ALU_SUB:  return a - b;
      isa_pkg::ALU_SLL:  return a << sh;
      // signed compare by flipping sign bits
      isa_pkg::ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      isa_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      isa_pkg::ALU_XOR:  return a ^ b;
      isa_pkg::ALU_SRL:  return a >> sh;
      isa_pkg::ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      isa_pkg::ALU_OR:   return a | b;
      isa_pkg::ALU_AND:  return a & b;
      default:           return b;  // LUI
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(isa_pkg::alu_op_e op);
    case (op)
      isa_pkg::ALU_SLL:                   return 3'b001;
      isa_pkg::ALU_SLT:                   return 3'b010;
      isa_pkg::ALU_SLTU:                  return 3'b011;
      isa_pkg::ALU_XOR:                   return 3'b100;
      isa_pkg::ALU_SRL, isa_pkg::ALU_SRA: return 3'b101;
      isa_pkg::ALU_OR:                    return 3'b110;
      isa_pkg::ALU_AND:                   return 3'b111;
      default:                            return 3'b000;  // ADD/SUB
    endcase
  endfunction

  function automatic logic [31:0] encode_lui(logic [4:0] rd, logic [19:0] upper);
    return {upper, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] encode_addi(logic [4:0] rd, logic [11:0] imm);
    return {imm, rd, 3'b000, rd, 7'b0010011};  // rd = rd + imm
  endfunction

  function automatic logic [31:0] encode_sw(logic [4:0] rs2, logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};  // base x0
  endfunction

  // operation under test, x1 op x2 (or imm) into rd
  function automatic logic [31:0] encode_alu(test_t t);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = funct3_of(t.op);
    f7 = (t.op == isa_pkg::ALU_SUB || t.op == isa_pkg::ALU_SRA) ? 7'b0100000 : 7'b0;
    if (t.op == isa_pkg::ALU_PASS_B)
      return encode_lui(t.rd, t.b[31:12]);
    if (!t.imm)
      return {f7, 5'd2, 5'd1, f3, t.rd, 7'b0110011};
    if (f3 == 3'b001 || f3 == 3'b101)
      return {f7, t.b[4:0], 5'd1, f3, t.rd, 7'b0010011};  // shamt form
    return {t.b[11:0], 5'd1, f3, t.rd, 7'b0010011};
  endfunction

  //////////////////////////////////////////////////
  // table and program image
  //////////////////////////////////////////////////

  task automatic load_table();
    //           name         op                  a              b              imm   rd
    tests[0]  = '{"add     ", isa_pkg::ALU_ADD,  32'h7fff_ffff, 32'h0000_0001, 1'b0, 5'd3, '0};
    tests[1]  = '{"sub     ", isa_pkg::ALU_SUB,  32'h0000_0000, 32'h0000_0001, 1'b0, 5'd3, '0};
    tests[2]  = '{"sll     ", isa_pkg::ALU_SLL,  32'h0000_0001, 32'h0000_003f, 1'b0, 5'd3, '0};
    tests[3]  = '{"slt     ", isa_pkg::ALU_SLT,  32'h8000_0000, 32'h7fff_ffff, 1'b0, 5'd3, '0};
    tests[4]  = '{"sltu    ", isa_pkg::ALU_SLTU, 32'h8000_0000, 32'h7fff_ffff, 1'b0, 5'd3, '0};
    tests[5]  = '{"xor     ", isa_pkg::ALU_XOR,  32'ha5a5_a5a5, 32'h0ff0_0ff0, 1'b0, 5'd3, '0};
    tests[6]  = '{"srl     ", isa_pkg::ALU_SRL,  32'h8000_0000, 32'h0000_0021, 1'b0, 5'd3, '0};
    tests[7]  = '{"sra     ", isa_pkg::ALU_SRA,  32'h8000_0000, 32'h0000_0004, 1'b0, 5'd3, '0};
    tests[8]  = '{"or      ", isa_pkg::ALU_OR,   32'h1234_0000, 32'h0000_5678, 1'b0, 5'd3, '0};
    tests[9]  = '{"and     ", isa_pkg::ALU_AND,  32'hdead_beef, 32'h0000_ffff, 1'b0, 5'd3, '0};
    tests[10] = '{"slt_neg ", isa_pkg::ALU_SLT,  32'hffff_ffff, 32'h0000_0000, 1'b0, 5'd3, '0};
    tests[11] = '{"addi    ", isa_pkg::ALU_ADD,  32'h0000_0010, 32'hffff_f800, 1'b1, 5'd3, '0};
    tests[12] = '{"slti    ", isa_pkg::ALU_SLT,  32'hffff_fffe, 32'hffff_ffff, 1'b1, 5'd3, '0};
    tests[13] = '{"sltiu   ", isa_pkg::ALU_SLTU, 32'h0000_0001, 32'hffff_ffff, 1'b1, 5'd3, '0};
    tests[14] = '{"xori    ", isa_pkg::ALU_XOR,  32'h0f0f_0f0f, 32'hffff_fff0, 1'b1, 5'd3, '0};
    tests[15] = '{"ori     ", isa_pkg::ALU_OR,   32'h0000_0100, 32'h0000_07ff, 1'b1, 5'd3, '0};
    tests[16] = '{"andi    ", isa_pkg::ALU_AND,  32'hffff_1234, 32'h0000_00ff, 1'b1, 5'd3, '0};
    tests[17] = '{"slli_0  ", isa_pkg::ALU_SLL,  32'h0000_0003, 32'h0000_0000, 1'b1, 5'd3, '0};
    tests[18] = '{"srli_31 ", isa_pkg::ALU_SRL,  32'h8000_0000, 32'h0000_001f, 1'b1, 5'd3, '0};
    tests[19] = '{"srai_31 ", isa_pkg::ALU_SRA,  32'h8000_0000, 32'h0000_001f, 1'b1, 5'd3, '0};
    tests[20] = '{"lui     ", isa_pkg::ALU_PASS_B, 32'h0,       32'habcd_e000, 1'b1, 5'd3, '0};
    tests[21] = '{"add_x0  ", isa_pkg::ALU_ADD,  32'h0000_0005, 32'h0000_0007, 1'b0, 5'd0, '0};
  endtask

  task automatic put_word(int unsigned idx, logic [31:0] w);
    imem[idx[IMEM_AW-1:0]] = w;
  endtask

  // per entry load x1, load x2, op, store, two NOPs
  task automatic build_program();
    int unsigned base;
    for (int unsigned w = 0; w < IMEM_WORDS; w++)
      put_word(w, isa_pkg::NOP_INSTR);
    for (int i = 0; i < NUM_TESTS; i++)
    begin
      base = 8 * i;
      tests[i].exp = (tests[i].rd == 5'd0) ? 32'h0
                                           : ref_result(tests[i].op, tests[i].a, tests[i].b);
      // upper part takes the carry of the sign-extended low part
      put_word(base,     encode_lui(5'd1, tests[i].a[31:12] + {19'b0, tests[i].a[11]}));
      put_word(base + 1, encode_addi(5'd1, tests[i].a[11:0]));
      put_word(base + 2, encode_lui(5'd2, tests[i].b[31:12] + {19'b0, tests[i].b[11]}));
      put_word(base + 3, encode_addi(5'd2, tests[i].b[11:0]));
      put_word(base + 4, encode_alu(tests[i]));
      put_word(base + 5, encode_sw(tests[i].rd, 12'(4 * i)));
    end
  endtask

  //////////////////////////////////////////////////
  // memory models and store monitor
  //////////////////////////////////////////////////

  function automatic int draw_delay();
    return int'($unsigned($random(seed)) % 32'd4);  // 0..3 cycles
  endfunction

  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (idx[31:IMEM_AW] != '0)
      return isa_pkg::NOP_INSTR;  // past the image
    return imem[idx[IMEM_AW-1:0]];
  endfunction

  initial
  begin : imem_model
    int          dly;
    logic [31:0] addr;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    forever
    begin
      @(negedge clk);
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (rst_n && instr_req_o)
      begin
        dly = draw_delay();
        repeat (dly) @(negedge clk);
        instr_gnt_i = 1'b1;
        addr        = instr_addr_o;
        @(negedge clk);
        instr_gnt_i = 1'b0;           // rvalid at least one cycle after gnt
        dly = draw_delay();
        repeat (dly) @(negedge clk);
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = fetch_word(addr);
      end
    end
  end

  initial
  begin : dmem_model
    int dly;
    data_gnt_i = 1'b0;
    forever
    begin
      @(negedge clk);
      data_gnt_i = 1'b0;
      if (rst_n && data_req_o)
      begin
        dly = draw_delay();
        repeat (dly) @(negedge clk);
        data_gnt_i = 1'b1;            // store completes in this cycle
      end
    end
  end

  always @(posedge clk)
  begin
    if (rst_n && data_req_o && data_gnt_i)
    begin
      store_q.push_back({data_addr_o, data_wdata_o});
      store_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // sequence and checks
  //////////////////////////////////////////////////

  task automatic record_result(logic [63:0] label, logic ok);
    if (ok)
    begin
      pass_cnt++;
      $display("test %s ok", label);
    end
    else
    begin
      fail_cnt++;
      $display("test %s failed", label);
    end
  endtask

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d stores seen", WATCHDOG_NS, store_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin : main
    store_t      got;
    logic [31:0] exp_addr;
    logic        ok;
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    load_table();
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // nothing may move before fetch is enabled
    ok = 1'b1;
    repeat (IDLE_CYCLES)
    begin
      @(negedge clk);
      assert (!instr_req_o && !data_req_o)
      else
      begin
        $display("memory request raised while fetch_enable_i is low");
        ok = 1'b0;
      end
    end
    fetch_enable_i = 1'b1;
    while (!instr_req_o)
      @(negedge clk);
    assert (instr_addr_o == BOOT_ADDR)
    else
    begin
      $display("Error: startup instr_addr_o expected %h got %h", BOOT_ADDR, instr_addr_o);
      ok = 1'b0;
    end
    record_result("startup ", ok);

    // one store per entry, in program order
    for (int i = 0; i < NUM_TESTS; i++)
    begin
      while (store_q.size() == 0)
        @(negedge clk);
      got      = store_q.pop_front();
      exp_addr = 32'(4 * i);
      ok       = 1'b1;
      assert (got.addr == exp_addr)
      else
      begin
        $display("Error: %s data_addr_o expected %h got %h", tests[i].name, exp_addr,
                 got.addr);
        ok = 1'b0;
      end
      assert (got.data == tests[i].exp)
      else
      begin
        $display("Error: %s data_wdata_o expected %h got %h", tests[i].name, tests[i].exp,
                 got.data);
        ok = 1'b0;
      end
      record_result(tests[i].name, ok);
    end

    // NOPs only from here
    repeat (DRAIN_CYCLES) @(negedge clk);
    ok = 1'b1;
    assert (store_cnt == NUM_TESTS)
    else
    begin
      $display("%0d stores arrived where %0d were expected", store_cnt, NUM_TESTS);
      ok = 1'b0;
    end
    record_result("drain   ", ok);

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== fetch/if_stage.sv ====
// instruction fetch stage: pc, instruction-memory request FSM and the fetch/decode register
`timescale 1ns/100ps

module if_stage (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                fetch_enable_i,
  input  core_pkg::word_t     boot_addr_i,

  // instruction memory
  output logic                instr_req_o,
  output core_pkg::word_t     instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  core_pkg::word_t     instr_rdata_i,

  // towards decode
  input  logic                id_ready_i,
  output core_pkg::if_id_t    if_id_o
);

  typedef enum logic [1:0] {
    FETCH_IDLE,   // nothing outstanding
    FETCH_REQ,    // req high, waiting for gnt
    FETCH_WAIT    // granted, waiting for rvalid
  } fetch_state_e;

  fetch_state_e      state_q, state_d;
  core_pkg::word_t   pc_q;
  logic              started_q;  // boot address taken
  logic              issue;      // start a new fetch
  core_pkg::if_id_t  if_id_q;

  // one fetch at a time, only once decode has room for the word
  assign issue = fetch_enable_i && (!if_id_q.valid || id_ready_i);

  //////////////////////////////////////////////////
  // request FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: if (issue)          state_d = FETCH_REQ;
      FETCH_REQ:  if (instr_gnt_i)    state_d = FETCH_WAIT;
      FETCH_WAIT: if (instr_rvalid_i) state_d = FETCH_IDLE;
      default:                        state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= FETCH_IDLE;
      pc_q      <= core_pkg::PC_RESET;
      started_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == FETCH_IDLE && issue && !started_q)
      begin
        pc_q      <= boot_addr_i;  // first enable samples boot address
        started_q <= 1'b1;
      end
      else if (state_q == FETCH_REQ && instr_gnt_i)
        pc_q <= pc_q + 32'd4;      // next sequential word
    end
  end

  assign instr_req_o  = (state_q == FETCH_REQ);
  assign instr_addr_o = pc_q;  // stable until gnt

  //////////////////////////////////////////////////
  // fetch/decode register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      if_id_q <= '0;
    else if (state_q == FETCH_WAIT && instr_rvalid_i)
    begin
      if_id_q.valid <= 1'b1;
      if_id_q.instr <= instr_rdata_i;
      if_id_q.pc    <= pc_q - 32'd4;  // pc already stepped at gnt
    end
    else if (id_ready_i)
      if_id_q.valid <= 1'b0;          // taken by decode
  end

  assign if_id_o = if_id_q;

  // req/addr held steady while the memory stalls the grant
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  // no response without a granted request
  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> state_q != FETCH_IDLE);

endmodule

// ==== rtl/ex_stage.sv ====
// execute stage: ALU, register write-back and word store requests to data memory
`timescale 1ns/100ps

module ex_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::id_ex_t    id_ex_i,
  output logic                ex_ready_o,
  output core_pkg::wb_fwd_t   wb_o,

  // data memory, stores only
  output logic                data_req_o,
  input  logic                data_gnt_i,
  output core_pkg::word_t     data_addr_o,
  output core_pkg::word_t     data_wdata_o
);

  core_pkg::word_t alu_result;
  logic [4:0]      shamt;

  assign shamt = id_ex_i.operand_b[4:0];  // low five bits only

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  always_comb
  begin
    case (id_ex_i.alu_op)
      isa_pkg::ALU_ADD:  alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      isa_pkg::ALU_SUB:  alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      isa_pkg::ALU_SLL:  alu_result = id_ex_i.operand_a << shamt;
      isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(id_ex_i.operand_a) <
                                              $signed(id_ex_i.operand_b)};
      isa_pkg::ALU_SLTU: alu_result = {31'b0, id_ex_i.operand_a < id_ex_i.operand_b};
      isa_pkg::ALU_XOR:  alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      isa_pkg::ALU_SRL:  alu_result = id_ex_i.operand_a >> shamt;
      isa_pkg::ALU_SRA:  alu_result = $unsigned($signed(id_ex_i.operand_a) >>> shamt);
      isa_pkg::ALU_OR:   alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      isa_pkg::ALU_AND:  alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      default:           alu_result = id_ex_i.operand_b;  // LUI
    endcase
  end

  // ALU ops leave after one cycle, writing at that edge
  assign wb_o.we    = id_ex_i.valid && id_ex_i.reg_we;
  assign wb_o.rd    = id_ex_i.rd;
  assign wb_o.wdata = alu_result;

  //////////////////////////////////////////////////
  // store port
  //////////////////////////////////////////////////

  // the entry sits in id_ex until gnt, so addr/data hold
  assign data_req_o   = id_ex_i.valid && id_ex_i.store_en;
  assign data_addr_o  = alu_result;          // rs1 + imm_s
  assign data_wdata_o = id_ex_i.store_data;

  assign ex_ready_o = !data_req_o || data_gnt_i;  // store done in gnt cycle

  // the whole pipe must stall behind a pending store
  a_store_stable: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o));

endmodule

// ==== rtl/mini_riscv_core.sv ====
// top of the three-stage RV32I core, connects fetch, decode and execute to the memory ports
`timescale 1ns/100ps

module mini_riscv_core (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              fetch_enable_i,
  input  core_pkg::word_t   boot_addr_i,

  // instruction memory
  output logic              instr_req_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  output core_pkg::word_t   instr_addr_o,
  input  core_pkg::word_t   instr_rdata_i,

  // data memory, word stores
  output logic              data_req_o,
  input  logic              data_gnt_i,
  output core_pkg::word_t   data_addr_o,
  output core_pkg::word_t   data_wdata_o
);

  core_pkg::if_id_t  if_id;     // fetch -> decode
  core_pkg::id_ex_t  id_ex;     // decode -> execute
  core_pkg::wb_fwd_t wb;        // execute -> regfile and forwarding
  logic              id_ready;  // decode can take if_id
  logic              ex_ready;  // execute can take id_ex

  //////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////

  if_stage u_if_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .id_ready_i     (id_ready),
    .if_id_o        (if_id)
  );

  id_stage u_id_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_id_i    (if_id),
    .id_ready_o (id_ready),
    .ex_ready_i (ex_ready),
    .wb_i       (wb),
    .id_ex_o    (id_ex)
  );

  ex_stage u_ex_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex_i      (id_ex),
    .ex_ready_o   (ex_ready),
    .wb_o         (wb),
    .data_req_o   (data_req_o),
    .data_gnt_i   (data_gnt_i),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o)
  );

endmodule
